//--- verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath and register file sizing
`define RV_XLEN       32
`define RV_REG_AW     5
`define RV_NREGS      32

// Data RAM, addressed by word
`define RV_DMEM_WORDS 64
`define RV_DMEM_AW    6

// Major opcodes of the kept instructions
`define RV_OP_RTYPE   7'b0110011
`define RV_OP_ITYPE   7'b0010011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011

// funct3 of the kept ALU operations
`define RV_F3_ADD     3'b000
`define RV_F3_XOR     3'b100
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct7 that turns ADD into SUB
`define RV_F7_SUB     7'b0100000

`endif

//--- verilog/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

  // ====================
  // Instruction word
  // ====================

  // One 32-bit word, read either as R-type or as I/S-type
  typedef union packed {
    // R view
    struct packed {
      logic [6:0]            funct7;
      logic [`RV_REG_AW-1:0] rs2;
      logic [`RV_REG_AW-1:0] rs1;
      logic [2:0]            funct3;
      logic [`RV_REG_AW-1:0] rd;
      logic [6:0]            opcode;
    } r;
    // I/S view, imm_hi is imm[11:5] and also funct7 for R-type
    struct packed {
      logic [6:0]            imm_hi;
      logic [`RV_REG_AW-1:0] rs2_or_imm_lo;
      logic [`RV_REG_AW-1:0] rs1;
      logic [2:0]            funct3;
      logic [`RV_REG_AW-1:0] rd_or_imm_lo;
      logic [6:0]            opcode;
    } is;
  } instr_u;

  // ====================
  // Control encodings
  // ====================

  // ALU operation, loads and stores use add for the address
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  logic [`RV_XLEN-1:0]   instr_i,
  input  logic                  stall_i,
  input  logic                  wb_valid_i,
  input  logic [`RV_REG_AW-1:0] wb_rd_i,
  input  logic [`RV_XLEN-1:0]   wb_data_i,
  output logic [`RV_REG_AW-1:0] de_rs1_o,
  output logic [`RV_REG_AW-1:0] de_rs2_o,
  output logic                  ex_valid_o,
  output logic [`RV_REG_AW-1:0] ex_rd_o,
  output logic [`RV_REG_AW-1:0] ex_rs1_o,
  output logic [`RV_REG_AW-1:0] ex_rs2_o,
  output logic [`RV_XLEN-1:0]   ex_rs1_data_o,
  output logic [`RV_XLEN-1:0]   ex_rs2_data_o,
  output logic [`RV_XLEN-1:0]   ex_imm_o,
  output rv_pkg::alu_op_e       ex_alu_op_o,
  output logic                  ex_use_imm_o,
  output logic                  ex_is_load_o,
  output logic                  ex_is_store_o,
  output logic                  ex_writes_rd_o
);

  logic                  de_valid_q;
  rv_pkg::instr_u        de_instr_q;

  logic                  dec_ok;
  logic                  dec_go;
  logic [`RV_REG_AW-1:0] dec_rs1;
  logic [`RV_REG_AW-1:0] dec_rs2;
  logic [`RV_XLEN-1:0]   dec_imm;
  rv_pkg::alu_op_e       dec_alu_op;
  logic                  dec_use_imm;
  logic                  dec_is_load;
  logic                  dec_is_store;

  logic [`RV_XLEN-1:0]   rf_q [`RV_NREGS];
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;

  // ====================
  // Decode register
  // ====================

  // Holds while stalled, takes a bubble when nothing is offered
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      de_valid_q <= 1'b0;
    end else if (!stall_i) begin
      de_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && !stall_i) begin
      de_instr_q <= instr_i;
    end
  end

  // ====================
  // Instruction decoder
  // ====================

  always_comb begin
    dec_ok       = 1'b0;
    dec_rs1      = '0;
    dec_rs2      = '0;
    dec_alu_op   = rv_pkg::ALU_ADD;
    dec_use_imm  = 1'b0;
    dec_is_load  = 1'b0;
    dec_is_store = 1'b0;
    // I-type immediate by default
    dec_imm      = {{(`RV_XLEN-12){de_instr_q.is.imm_hi[6]}},
                    de_instr_q.is.imm_hi, de_instr_q.is.rs2_or_imm_lo};
    case (de_instr_q.r.opcode)
      `RV_OP_RTYPE: begin
        dec_rs1 = de_instr_q.r.rs1;
        dec_rs2 = de_instr_q.r.rs2;
        dec_ok  = 1'b1;
        case (de_instr_q.r.funct3)
          `RV_F3_ADD: begin
            dec_alu_op = (de_instr_q.r.funct7 == `RV_F7_SUB) ? rv_pkg::ALU_SUB
                                                              : rv_pkg::ALU_ADD;
          end
          `RV_F3_XOR: dec_alu_op = rv_pkg::ALU_XOR;
          `RV_F3_OR:  dec_alu_op = rv_pkg::ALU_OR;
          `RV_F3_AND: dec_alu_op = rv_pkg::ALU_AND;
          // Shifts and compares are not supported
          default:    dec_ok = 1'b0;
        endcase
      end
      `RV_OP_ITYPE: begin
        // Only ADDI among the immediate ops
        dec_rs1     = de_instr_q.is.rs1;
        dec_use_imm = 1'b1;
        dec_ok      = (de_instr_q.is.funct3 == `RV_F3_ADD);
      end
      `RV_OP_LOAD: begin
        dec_rs1     = de_instr_q.is.rs1;
        dec_use_imm = 1'b1;
        dec_is_load = 1'b1;
        dec_ok      = 1'b1;
      end
      `RV_OP_STORE: begin
        dec_rs1      = de_instr_q.is.rs1;
        dec_rs2      = de_instr_q.r.rs2;
        dec_use_imm  = 1'b1;
        dec_is_store = 1'b1;
        dec_ok       = 1'b1;
        // S-type splits the immediate around rs2/rs1
        dec_imm      = {{(`RV_XLEN-12){de_instr_q.is.imm_hi[6]}},
                        de_instr_q.is.imm_hi, de_instr_q.is.rd_or_imm_lo};
      end
      default: dec_ok = 1'b0;
    endcase
    // A bubble or an unknown word reads no register
    if (!de_valid_q || !dec_ok) begin
      dec_rs1 = '0;
      dec_rs2 = '0;
    end
  end

  assign dec_go   = de_valid_q && dec_ok && !stall_i;
  assign de_rs1_o = dec_rs1;
  assign de_rs2_o = dec_rs2;

  // ====================
  // Register file
  // ====================

  // x0 is never written, reads of x0 are forced to zero
  always_ff @(posedge clk_i) begin
    if (wb_valid_i && (wb_rd_i != '0)) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  // Write-through from the writeback port
  assign rs1_data = (dec_rs1 == '0) ? '0 :
                    (wb_valid_i && (wb_rd_i == dec_rs1)) ? wb_data_i : rf_q[dec_rs1];
  assign rs2_data = (dec_rs2 == '0) ? '0 :
                    (wb_valid_i && (wb_rd_i == dec_rs2)) ? wb_data_i : rf_q[dec_rs2];

  // ====================
  // Decode to execute
  // ====================

  // Control flags are cleared on a bubble
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ex_valid_o     <= 1'b0;
      ex_is_load_o   <= 1'b0;
      ex_is_store_o  <= 1'b0;
      ex_writes_rd_o <= 1'b0;
    end else begin
      ex_valid_o     <= dec_go;
      ex_is_load_o   <= dec_go && dec_is_load;
      ex_is_store_o  <= dec_go && dec_is_store;
      ex_writes_rd_o <= dec_go && !dec_is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rd_o       <= de_instr_q.r.rd;
    ex_rs1_o      <= dec_rs1;
    ex_rs2_o      <= dec_rs2;
    ex_rs1_data_o <= rs1_data;
    ex_rs2_data_o <= rs2_data;
    ex_imm_o      <= dec_imm;
    ex_alu_op_o   <= dec_alu_op;
    ex_use_imm_o  <= dec_use_imm;
  end

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module hazard_unit (
  input  logic [`RV_REG_AW-1:0] de_rs1_i,
  input  logic [`RV_REG_AW-1:0] de_rs2_i,
  input  logic [`RV_REG_AW-1:0] ex_rs1_i,
  input  logic [`RV_REG_AW-1:0] ex_rs2_i,
  input  logic [`RV_REG_AW-1:0] ex_rd_i,
  input  logic                  ex_is_load_i,
  input  logic                  ex_valid_i,
  input  logic [`RV_REG_AW-1:0] me_rd_i,
  input  logic                  me_writes_rd_i,
  input  logic [`RV_REG_AW-1:0] wb_rd_i,
  input  logic                  wb_valid_i,
  output logic                  stall_o,
  output rv_pkg::fwd_sel_e      fwd_a_o,
  output rv_pkg::fwd_sel_e      fwd_b_o
);

  logic load_in_ex;

  // Youngest producer wins, x0 never forwards
  function automatic rv_pkg::fwd_sel_e pick_src(
    input logic [`RV_REG_AW-1:0] rs,
    input logic [`RV_REG_AW-1:0] me_rd,
    input logic                  me_writes,
    input logic [`RV_REG_AW-1:0] wb_rd,
    input logic                  wb_writes
  );
    rv_pkg::fwd_sel_e sel;
    sel = rv_pkg::FWD_REG;
    if (me_writes && (me_rd != '0) && (me_rd == rs)) begin
      sel = rv_pkg::FWD_MEM;
    end else if (wb_writes && (wb_rd != '0) && (wb_rd == rs)) begin
      sel = rv_pkg::FWD_WB;
    end
    return sel;
  endfunction

  // ====================
  // Load-use stall
  // ====================

  // Load data is only ready after memory, one bubble is needed
  assign load_in_ex = ex_valid_i && ex_is_load_i && (ex_rd_i != '0);
  assign stall_o    = load_in_ex && ((ex_rd_i == de_rs1_i) || (ex_rd_i == de_rs2_i));

  // ====================
  // Forward selection
  // ====================

  assign fwd_a_o = pick_src(ex_rs1_i, me_rd_i, me_writes_rd_i, wb_rd_i, wb_valid_i);
  assign fwd_b_o = pick_src(ex_rs2_i, me_rd_i, me_writes_rd_i, wb_rd_i, wb_valid_i);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ex_valid_i,
  input  logic [`RV_REG_AW-1:0] ex_rd_i,
  input  logic [`RV_XLEN-1:0]   ex_rs1_data_i,
  input  logic [`RV_XLEN-1:0]   ex_rs2_data_i,
  input  logic [`RV_XLEN-1:0]   ex_imm_i,
  input  rv_pkg::alu_op_e       ex_alu_op_i,
  input  logic                  ex_use_imm_i,
  input  logic                  ex_is_load_i,
  input  logic                  ex_is_store_i,
  input  logic                  ex_writes_rd_i,
  input  rv_pkg::fwd_sel_e      fwd_a_i,
  input  rv_pkg::fwd_sel_e      fwd_b_i,
  input  logic [`RV_XLEN-1:0]   me_result_i,
  input  logic [`RV_XLEN-1:0]   wb_data_i,
  output logic                  me_valid_o,
  output logic [`RV_REG_AW-1:0] me_rd_o,
  output logic                  me_writes_rd_o,
  output logic                  me_is_load_o,
  output logic                  me_is_store_o,
  output logic [`RV_XLEN-1:0]   me_addr_o,
  output logic [`RV_XLEN-1:0]   me_store_data_o
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b_reg;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_result;

  // Memory first, then writeback, then the value read in decode
  function automatic logic [`RV_XLEN-1:0] fwd_mux(
    input rv_pkg::fwd_sel_e    sel,
    input logic [`RV_XLEN-1:0] reg_val,
    input logic [`RV_XLEN-1:0] me_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      rv_pkg::FWD_MEM: return me_val;
      rv_pkg::FWD_WB:  return wb_val;
      default:         return reg_val;
    endcase
  endfunction

  // ====================
  // Operands and ALU
  // ====================

  assign op_a     = fwd_mux(fwd_a_i, ex_rs1_data_i, me_result_i, wb_data_i);
  assign op_b_reg = fwd_mux(fwd_b_i, ex_rs2_data_i, me_result_i, wb_data_i);
  // Stores add the immediate, rs2 goes out as store data
  assign op_b     = ex_use_imm_i ? ex_imm_i : op_b_reg;

  always_comb begin
    case (ex_alu_op_i)
      rv_pkg::ALU_SUB: alu_result = op_a - op_b;
      rv_pkg::ALU_AND: alu_result = op_a & op_b;
      rv_pkg::ALU_OR:  alu_result = op_a | op_b;
      rv_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      default:         alu_result = op_a + op_b;
    endcase
  end

  // ====================
  // Execute to memory
  // ====================

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      me_valid_o     <= 1'b0;
      me_writes_rd_o <= 1'b0;
      me_is_load_o   <= 1'b0;
      me_is_store_o  <= 1'b0;
    end else begin
      me_valid_o     <= ex_valid_i;
      me_writes_rd_o <= ex_writes_rd_i;
      me_is_load_o   <= ex_is_load_i;
      me_is_store_o  <= ex_is_store_i;
    end
  end

  // Result doubles as the memory address
  always_ff @(posedge clk_i) begin
    me_rd_o         <= ex_rd_i;
    me_addr_o       <= alu_result;
    me_store_data_o <= op_b_reg;
  end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module memory_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  me_valid_i,
  input  logic [`RV_REG_AW-1:0] me_rd_i,
  input  logic                  me_writes_rd_i,
  input  logic                  me_is_load_i,
  input  logic                  me_is_store_i,
  input  logic [`RV_XLEN-1:0]   me_addr_i,
  input  logic [`RV_XLEN-1:0]   me_store_data_i,
  output logic                  wb_valid_o,
  output logic [`RV_REG_AW-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]   wb_data_o
);

  logic [`RV_XLEN-1:0]    dmem_q [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] word_addr;
  logic [`RV_XLEN-1:0]    load_data;
  logic [`RV_XLEN-1:0]    result;
  logic                   retire_wr;

  // Byte offset bits are dropped, only word accesses exist
  assign word_addr = me_addr_i[`RV_DMEM_AW+1:2];

  // ====================
  // Data RAM
  // ====================

  // Store commits on the edge that moves it out of memory
  always_ff @(posedge clk_i) begin
    if (me_valid_i && me_is_store_i) begin
      dmem_q[word_addr] <= me_store_data_i;
    end
  end

  // Asynchronous read
  assign load_data = dmem_q[word_addr];
  assign result    = me_is_load_i ? load_data : me_addr_i;

  // Stores and x0 targets retire silently
  assign retire_wr = me_valid_i && me_writes_rd_i && (me_rd_i != '0);

  // ====================
  // Memory to writeback
  // ====================

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= retire_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= me_rd_i;
    wb_data_o <= result;
  end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  logic [`RV_XLEN-1:0]   instr_i,
  output logic                  stall_o,
  output logic                  wb_valid_o,
  output logic [`RV_REG_AW-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]   wb_data_o
);

  // Decode outputs
  logic [`RV_REG_AW-1:0] de_rs1;
  logic [`RV_REG_AW-1:0] de_rs2;

  // ====================
  // Execute inputs
  // ====================
  logic                  ex_valid;
  logic [`RV_REG_AW-1:0] ex_rd;
  logic [`RV_REG_AW-1:0] ex_rs1;
  logic [`RV_REG_AW-1:0] ex_rs2;
  logic [`RV_XLEN-1:0]   ex_rs1_data;
  logic [`RV_XLEN-1:0]   ex_rs2_data;
  logic [`RV_XLEN-1:0]   ex_imm;
  rv_pkg::alu_op_e       ex_alu_op;
  logic                  ex_use_imm;
  logic                  ex_is_load;
  logic                  ex_is_store;
  logic                  ex_writes_rd;
  rv_pkg::fwd_sel_e      fwd_a;
  rv_pkg::fwd_sel_e      fwd_b;

  // ====================
  // Memory inputs
  // ====================
  logic                  me_valid;
  logic [`RV_REG_AW-1:0] me_rd;
  logic                  me_writes_rd;
  logic                  me_is_load;
  logic                  me_is_store;
  logic [`RV_XLEN-1:0]   me_addr;
  logic [`RV_XLEN-1:0]   me_store_data;

  decode_stage i_decode_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .stall_i        (stall_o),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .wb_data_i      (wb_data_o),
    .de_rs1_o       (de_rs1),
    .de_rs2_o       (de_rs2),
    .ex_valid_o     (ex_valid),
    .ex_rd_o        (ex_rd),
    .ex_rs1_o       (ex_rs1),
    .ex_rs2_o       (ex_rs2),
    .ex_rs1_data_o  (ex_rs1_data),
    .ex_rs2_data_o  (ex_rs2_data),
    .ex_imm_o       (ex_imm),
    .ex_alu_op_o    (ex_alu_op),
    .ex_use_imm_o   (ex_use_imm),
    .ex_is_load_o   (ex_is_load),
    .ex_is_store_o  (ex_is_store),
    .ex_writes_rd_o (ex_writes_rd)
  );

  // Stall and forward selects come from registered stage state only
  hazard_unit i_hazard_unit (
    .de_rs1_i       (de_rs1),
    .de_rs2_i       (de_rs2),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_rd_i        (ex_rd),
    .ex_is_load_i   (ex_is_load),
    .ex_valid_i     (ex_valid),
    .me_rd_i        (me_rd),
    .me_writes_rd_i (me_writes_rd),
    .wb_rd_i        (wb_rd_o),
    .wb_valid_i     (wb_valid_o),
    .stall_o        (stall_o),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b)
  );

  // ALU result in memory feeds back as the memory forward path
  execute_stage i_execute_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_valid_i      (ex_valid),
    .ex_rd_i         (ex_rd),
    .ex_rs1_data_i   (ex_rs1_data),
    .ex_rs2_data_i   (ex_rs2_data),
    .ex_imm_i        (ex_imm),
    .ex_alu_op_i     (ex_alu_op),
    .ex_use_imm_i    (ex_use_imm),
    .ex_is_load_i    (ex_is_load),
    .ex_is_store_i   (ex_is_store),
    .ex_writes_rd_i  (ex_writes_rd),
    .fwd_a_i         (fwd_a),
    .fwd_b_i         (fwd_b),
    .me_result_i     (me_addr),
    .wb_data_i       (wb_data_o),
    .me_valid_o      (me_valid),
    .me_rd_o         (me_rd),
    .me_writes_rd_o  (me_writes_rd),
    .me_is_load_o    (me_is_load),
    .me_is_store_o   (me_is_store),
    .me_addr_o       (me_addr),
    .me_store_data_o (me_store_data)
  );

  memory_stage i_memory_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .me_valid_i      (me_valid),
    .me_rd_i         (me_rd),
    .me_writes_rd_i  (me_writes_rd),
    .me_is_load_i    (me_is_load),
    .me_is_store_i   (me_is_store),
    .me_addr_i       (me_addr),
    .me_store_data_i (me_store_data),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o)
  );

endmodule

//--- test/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  logic [`RV_XLEN-1:0]   instr_i;
  logic                  stall_o;
  logic                  wb_valid_o;
  logic [`RV_REG_AW-1:0] wb_rd_o;
  logic [`RV_XLEN-1:0]   wb_data_o;

  // Program and expected writebacks from the data file
  logic [`RV_XLEN-1:0]   instr_q[$];
  logic [`RV_REG_AW-1:0] exp_rd_q[$];
  logic [`RV_XLEN-1:0]   exp_data_q[$];
  int                    exp_idx_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int wb_count    = 0;
  bit stall_seen  = 1'b0;

  rv_core dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_o       (stall_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  // 4 ns period
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ====================
  // Helpers
  // ====================

  task automatic check_value(input logic [`RV_XLEN-1:0] actual,
                             input logic [`RV_XLEN-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
               $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on first error");
    end
  endtask

  task automatic stop_with_error(input string reason);
    $display("Error at %0t ns: %s", $time, reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Readable text of an instruction word, for messages only
  function automatic string describe_instr(input logic [`RV_XLEN-1:0] word);
    rv_pkg::instr_u u;
    string          name;
    u = word;
    case (u.r.opcode)
      `RV_OP_RTYPE: begin
        case (u.r.funct3)
          `RV_F3_XOR: name = "xor";
          `RV_F3_OR:  name = "or";
          `RV_F3_AND: name = "and";
          default:    name = (u.r.funct7 == `RV_F7_SUB) ? "sub" : "add";
        endcase
        return $sformatf("%s x%0d, x%0d, x%0d", name, u.r.rd, u.r.rs1, u.r.rs2);
      end
      `RV_OP_ITYPE: begin
        return $sformatf("addi x%0d, x%0d, %0d", u.r.rd, u.is.rs1,
                         $signed({u.is.imm_hi, u.is.rs2_or_imm_lo}));
      end
      `RV_OP_LOAD: begin
        return $sformatf("lw x%0d, %0d(x%0d)", u.r.rd,
                         $signed({u.is.imm_hi, u.is.rs2_or_imm_lo}), u.is.rs1);
      end
      `RV_OP_STORE: begin
        // S-type offset is split around rs2 and rs1
        return $sformatf("sw x%0d, %0d(x%0d)", u.r.rs2,
                         $signed({u.is.imm_hi, u.is.rd_or_imm_lo}), u.is.rs1);
      end
      default: return $sformatf("unknown word %h", word);
    endcase
  endfunction

  // Tags are I for an instruction, E for an expected writeback, # for a comment
  task automatic load_testdata();
    int                  fd;
    int                  n;
    int                  rd;
    logic [7:0]          tag;
    logic [`RV_XLEN-1:0] word;
    logic [8*128-1:0]    line_buf;
    fd = $fopen("test/rv_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_error("could not open test/rv_testdata.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        break;
      end
      if (tag == "#") begin
        n = $fgets(line_buf, fd);
      end else if (tag == "I") begin
        n = $fscanf(fd, "%h", word);
        instr_q.push_back(word);
      end else if (tag == "E") begin
        n = $fscanf(fd, "%d %h", rd, word);
        exp_rd_q.push_back(rd[`RV_REG_AW-1:0]);
        exp_data_q.push_back(word);
        exp_idx_q.push_back(instr_q.size() - 1);
      end else begin
        stop_with_error("data file has a line with an unknown tag");
      end
    end
    $fclose(fd);
  endtask

  // ====================
  // Writeback monitor
  // ====================

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (wb_valid_o === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        stop_with_error($sformatf("writeback to x%0d with no expected record left",
                                  wb_rd_o));
      end else begin
        check_value(32'(wb_rd_o), 32'(exp_rd_q[0]),
                    $sformatf("writeback %0d rd, %s", wb_count,
                              describe_instr(instr_q[exp_idx_q[0]])));
        check_value(wb_data_o, exp_data_q[0],
                    $sformatf("writeback %0d data, %s", wb_count,
                              describe_instr(instr_q[exp_idx_q[0]])));
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_idx_q.pop_front());
        wb_count++;
      end
    end
  end

  // Limit is zero until the program is loaded
  always @(posedge clk_i) begin
    cycle_count++;
    if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
      $display("Run timed out after %0d cycles with %0d writebacks still pending",
               cycle_count, exp_rd_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  // ====================
  // Stimulus
  // ====================

  initial begin
    bit accepted;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    load_testdata();
    cycle_limit = 10 * instr_q.size() + 100;

    // Ten cycles of reset, outputs must stay quiet
    repeat (10) begin
      @(negedge clk_i);
      check_value(32'(wb_valid_o), 32'h0, "wb_valid_o during reset");
      check_value(32'(stall_o), 32'h0, "stall_o during reset");
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value(32'(wb_valid_o), 32'h0, "wb_valid_o after reset");
    check_value(32'(stall_o), 32'h0, "stall_o after reset");

    // Hold each word until an edge with stall_o low takes it
    foreach (instr_q[i]) begin
      instr_valid_i = 1'b1;
      instr_i       = instr_q[i];
      accepted      = 1'b0;
      while (!accepted) begin
        if (stall_o) begin
          stall_seen = 1'b1;
        end
        accepted = !stall_o;
        @(negedge clk_i);
      end
    end
    instr_valid_i = 1'b0;
    instr_i       = '0;

    // Drain, then watch a few more cycles for stray pulses
    // Records never retired end the run through the cycle limit
    while (exp_rd_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (8) @(negedge clk_i);

    if (!stall_seen) begin
      stop_with_error("stall_o was never raised for a load followed by its user");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- test/rv_testdata.txt
# I <instruction word, hex>
# E <destination register, decimal> <writeback data, hex>
# ALU ops with forwarding at distance 1, 2 and 3
I 12300093
E 1 00000123
I fff00113
E 2 ffffffff
I 002081b3
E 3 00000122
I 40118233
E 4 ffffffff
I 5a500293
E 5 000005a5
I 0012f333
E 6 00000121
I 0012e3b3
E 7 000005a7
I 0012c433
E 8 00000486
# Write to x0 retires silently, then x0 reads as zero
I 00508013
I 001004b3
E 9 00000123
# Stores to words 2 and 3, loads back with load-use stalls
I 00302423
I 00402623
I 00802503
E 10 00000122
I 001505b3
E 11 00000245
I 00c02603
E 12 ffffffff
I 405606b3
E 13 fffffa5a
# Store then load of the same word, back to back
I 00702823
I 01002703
E 14 000005a7
# Store data forwarded from the previous instruction
I 07700793
E 15 00000077
I 00f02a23
I 01402803
E 16 00000077
I 00180893
E 17 00000078
# Offset with upper immediate bits set
I 02802023
I 02002a03
E 20 00000486
I 00000933
E 18 00000000
I fdd08993
E 19 00000100

//--- tb.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_core.sv
test/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_rv_core
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a pass status"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
